// File: obj_pkg.sv
// Sprite object table definitions
package obj_pkg;

    // Table geometry
    // Entry index bits per bank
    localparam int OBJ_AW      = 10;
    // Entries in one bank
    localparam int OBJ_ENTRIES = 1 << OBJ_AW;

    // Screen geometry
    // Position and line counter width
    localparam int POS_W    = 10;
    // Visible columns
    localparam int SCREEN_W = 384;
    // Tile edge in pixels
    localparam int TILE_PX  = 16;

    // Draw-list queue slots
    localparam int LIST_DEPTH = 4;

    // Upper attribute byte of the end entry
    localparam logic [7:0] END_TAG = 8'hFF;

    // Attribute word seen as sprite fields
    typedef struct packed {
        // Tiles tall minus one
        logic [3:0] vsize;
        // Tiles wide minus one
        logic [3:0] hsize;
        // Not decoded by the line scanner
        logic       rsv;
        logic       yflip;
        logic       xflip;
        // Palette select
        logic [4:0] pal;
    } obj_fields_t;

    // Attribute word seen as end marker
    typedef struct packed {
        // END_TAG here terminates the table
        logic [7:0] mark;
        logic [7:0] rest;
    } obj_tag_t;

    // Same 16 bits, two decodings
    typedef union packed {
        obj_fields_t fields;
        obj_tag_t    tag;
    } obj_attr_u;

endpackage

// File: obj_ram.sv
// Banked object table RAM
`timescale 1ns/100ps

module obj_ram
    import obj_pkg::*;
(
    input  logic              clk_cpu,
    input  logic              rst,
    input  logic              obank,

    // CPU write port
    input  logic              cs,
    output logic              ok,
    input  logic [1:0]        dsn,
    input  logic [13:1]       main_addr,
    input  logic [15:0]       main_dout,

    // Engine read port
    input  logic [OBJ_AW-1:0] obj_addr,
    output logic [15:0]       obj_x,
    output logic [15:0]       obj_y,
    output logic [15:0]       obj_code,
    output logic [15:0]       obj_attr
);

    // Word order inside an entry
    // 0 X, 1 Y, 2 code, 3 attr
    // One array per word, both banks stacked
    logic [15:0] tbl [0:3][0:2*OBJ_ENTRIES-1];

    logic [OBJ_AW:0] wr_addr;
    logic [OBJ_AW:0] rd_addr;

    // CPU bank is relative to obank
    assign wr_addr = {obank ^ main_addr[13], main_addr[12:3]};
    // Engine always sees the other bank
    assign rd_addr = {~obank, obj_addr};

    // Byte lane writes
    // Only the word picked by main_addr[2:1] is touched
    always_ff @(posedge clk_cpu) begin
        for (int w = 0; w < 4; w++) begin
            for (int b = 0; b < 2; b++) begin
                // dsn is active low per lane
                if (cs && main_addr[2:1] == 2'(w) && !dsn[b]) begin
                    tbl[w][wr_addr][b*8 +: 8] <= main_dout[b*8 +: 8];
                end
            end
        end
    end

    // Registered engine read
    // Data one cycle after obj_addr
    always_ff @(posedge clk_cpu) begin
        obj_x    <= tbl[0][rd_addr];
        obj_y    <= tbl[1][rd_addr];
        obj_code <= tbl[2][rd_addr];
        obj_attr <= tbl[3][rd_addr];
    end

    // Write acknowledge
    // Follows cs by one clock
    always_ff @(posedge clk_cpu) begin
        if (rst) begin
            ok <= 1'b0;
        end else begin
            ok <= cs;
        end
    end

endmodule

// File: obj_scan_ctrl.sv
// Object table line scan controller
`timescale 1ns/100ps

module obj_scan_ctrl
    import obj_pkg::*;
(
    input  logic              clk_cpu,
    input  logic              rst,
    input  logic              line_start,
    input  logic [15:0]       obj_attr,
    input  logic [2:0]        list_space,
    input  logic              pipe_busy,
    output logic [OBJ_AW-1:0] obj_addr,
    output logic              ent_valid,
    output logic              scan_done
);

    obj_attr_u  attr;
    // Walking the table for this line
    logic       scanning;
    // Read stages: address, data, checker
    logic       rd_issue;
    logic       rd_data;
    logic       rd_check;
    // End marker already seen
    logic       ended;
    // Waiting for the pipe to empty
    logic       done_pend;
    logic       is_mark;
    logic       mark_hit;
    logic       last_addr;
    logic [2:0] in_flight;
    logic       can_issue;

    assign attr = obj_attr;

    // End marker decode through the tag view
    assign is_mark  = attr.tag.mark == END_TAG;
    assign mark_hit = rd_data && !ended && is_mark;
    // Real entries only, nothing past the marker
    assign ent_valid = rd_data && !ended && !is_mark;

    assign last_addr = rd_issue && obj_addr == OBJ_AW'(OBJ_ENTRIES - 1);

    // Reads that may still push into the queue
    assign in_flight = {2'b00, rd_issue} + {2'b00, rd_data} + {2'b00, rd_check};
    assign can_issue = in_flight < list_space;

    always_ff @(posedge clk_cpu) begin
        if (rst) begin
            scanning  <= 1'b0;
            rd_issue  <= 1'b0;
            rd_data   <= 1'b0;
            rd_check  <= 1'b0;
            ended     <= 1'b0;
            done_pend <= 1'b0;
            scan_done <= 1'b0;
            obj_addr  <= '0;
        end else begin
            rd_data   <= rd_issue;
            rd_check  <= rd_data;
            scan_done <= 1'b0;
            if (line_start) begin
                // Restart from entry 0 on the next cycle
                scanning  <= 1'b1;
                ended     <= 1'b0;
                done_pend <= 1'b0;
                obj_addr  <= '0;
                rd_issue  <= can_issue;
            end else begin
                // Advance only after an actual read
                if (rd_issue) begin
                    obj_addr <= obj_addr + 1'b1;
                end
                if (mark_hit) begin
                    ended <= 1'b1;
                end
                // Stop at the marker or the last entry
                if (scanning && (last_addr || mark_hit)) begin
                    scanning  <= 1'b0;
                    done_pend <= 1'b1;
                end
                // Stall while the queue cannot take more
                rd_issue <= scanning && !last_addr && !mark_hit && can_issue;
                // Single pulse once everything has drained
                if (done_pend && !rd_issue && !rd_data && !pipe_busy) begin
                    scan_done <= 1'b1;
                    done_pend <= 1'b0;
                end
            end
        end
    end

endmodule

// File: obj_vcheck.sv
// Sprite vertical hit checker
`timescale 1ns/100ps

module obj_vcheck
    import obj_pkg::*;
(
    input  logic             clk_cpu,
    input  logic             rst,
    input  logic [POS_W-1:0] line,
    input  logic             ent_valid,
    input  logic [15:0]      obj_y,
    input  logic [15:0]      obj_attr,
    input  logic [15:0]      obj_code,
    output logic             v_valid,
    output logic             v_hit,
    output logic [3:0]       v_tile_row,
    output logic [3:0]       v_pix_row,
    output logic [15:0]      ent_code,
    output logic [3:0]       ent_hsize,
    output logic             ent_xflip,
    output logic [4:0]       ent_pal
);

    obj_attr_u        attr;
    logic [POS_W-1:0] offset;
    logic [POS_W-1:0] tile_idx;
    logic [3:0]       tile_row;
    logic [3:0]       pix_row;

    assign attr = obj_attr;

    // Line relative to sprite top, wraps past line 1023
    assign offset   = line - obj_y[POS_W-1:0];
    assign tile_idx = offset / POS_W'(TILE_PX);
    assign tile_row = tile_idx[3:0];
    assign pix_row  = 4'(offset % POS_W'(TILE_PX));

    always_ff @(posedge clk_cpu) begin
        if (rst) begin
            v_valid <= 1'b0;
        end else begin
            v_valid <= ent_valid;
        end
    end

    // Results and passed-on fields, in step with v_valid
    always_ff @(posedge clk_cpu) begin
        // Inside the sprite when offset < (vsize+1) tiles
        v_hit <= tile_idx <= POS_W'(attr.fields.vsize);
        // Flip mirrors both the tile and the pixel row
        if (attr.fields.yflip) begin
            v_tile_row <= attr.fields.vsize - tile_row;
            v_pix_row  <= pix_row ^ 4'hF;
        end else begin
            v_tile_row <= tile_row;
            v_pix_row  <= pix_row;
        end
        ent_code  <= obj_code;
        ent_hsize <= attr.fields.hsize;
        ent_xflip <= attr.fields.xflip;
        ent_pal   <= attr.fields.pal;
    end

endmodule

// File: obj_hcheck.sv
// Sprite horizontal visibility checker
`timescale 1ns/100ps

module obj_hcheck
    import obj_pkg::*;
(
    input  logic             clk_cpu,
    input  logic             rst,
    input  logic             ent_valid,
    input  logic [15:0]      obj_x,
    input  logic [15:0]      obj_attr,
    output logic             h_vis,
    output logic [POS_W-1:0] ent_x
);

    obj_attr_u        attr;
    logic [POS_W-1:0] xpos;
    // Sprite width in pixels
    logic [POS_W:0]   span;
    // Right edge, carry bit set past column 1023
    logic [POS_W:0]   right_edge;
    logic             on_screen;
    logic             wraps;

    assign attr = obj_attr;
    assign xpos = obj_x[POS_W-1:0];
    assign span = (POS_W+1)'((attr.fields.hsize + 32'd1) * TILE_PX);

    assign right_edge = {1'b0, xpos} + span;
    assign on_screen  = xpos < POS_W'(SCREEN_W);
    // Left edge wrap, x >= 1024 - width
    assign wraps      = right_edge[POS_W];

    always_ff @(posedge clk_cpu) begin
        if (rst) begin
            h_vis <= 1'b0;
        end else begin
            h_vis <= ent_valid && (on_screen || wraps);
        end
    end

    // Same stage as the vertical results
    always_ff @(posedge clk_cpu) begin
        ent_x <= xpos;
    end

endmodule

// File: obj_list_build.sv
// Draw-list builder and output queue
`timescale 1ns/100ps

module obj_list_build
    import obj_pkg::*;
(
    input  logic             clk_cpu,
    input  logic             rst,

    // Checker results
    input  logic             v_valid,
    input  logic             v_hit,
    input  logic [3:0]       v_tile_row,
    input  logic [3:0]       v_pix_row,
    input  logic [15:0]      ent_code,
    input  logic [3:0]       ent_hsize,
    input  logic             ent_xflip,
    input  logic [4:0]       ent_pal,
    input  logic             h_vis,
    input  logic [POS_W-1:0] ent_x,

    // Draw-list stream
    output logic             list_valid,
    input  logic             list_ready,
    output logic [15:0]      list_code,
    output logic [POS_W-1:0] list_x,
    output logic [3:0]       list_hsize,
    output logic             list_xflip,
    output logic [4:0]       list_pal,
    output logic [3:0]       list_row,

    // Pacing back to the scan controller
    output logic [2:0]       list_space,
    output logic             pipe_busy
);

    // Queue storage, one array per field
    logic [15:0]      q_code  [0:LIST_DEPTH-1];
    logic [POS_W-1:0] q_x     [0:LIST_DEPTH-1];
    logic [3:0]       q_hsize [0:LIST_DEPTH-1];
    logic             q_xflip [0:LIST_DEPTH-1];
    logic [4:0]       q_pal   [0:LIST_DEPTH-1];
    logic [3:0]       q_row   [0:LIST_DEPTH-1];

    logic [$clog2(LIST_DEPTH)-1:0] wr_ptr;
    logic [$clog2(LIST_DEPTH)-1:0] rd_ptr;
    logic [2:0]       count;
    logic             push;
    logic             pop;
    logic [15:0]      adj_code;

    // Visible on both axes
    assign push = v_valid && v_hit && h_vis;
    assign pop  = list_valid && list_ready;

    // Code steps by 16 per tile row
    assign adj_code = ent_code + {8'h00, v_tile_row, 4'h0};

    always_ff @(posedge clk_cpu) begin
        if (push) begin
            q_code[wr_ptr]  <= adj_code;
            q_x[wr_ptr]     <= ent_x;
            q_hsize[wr_ptr] <= ent_hsize;
            q_xflip[wr_ptr] <= ent_xflip;
            q_pal[wr_ptr]   <= ent_pal;
            q_row[wr_ptr]   <= v_pix_row;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_cpu) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head of queue, held until accepted
    assign list_valid = count != 3'd0;
    assign list_code  = q_code[rd_ptr];
    assign list_x     = q_x[rd_ptr];
    assign list_hsize = q_hsize[rd_ptr];
    assign list_xflip = q_xflip[rd_ptr];
    assign list_pal   = q_pal[rd_ptr];
    assign list_row   = q_row[rd_ptr];

    assign list_space = 3'(LIST_DEPTH) - count;
    // Something left to deliver
    assign pipe_busy  = v_valid || list_valid;

endmodule

// File: obj_line_top.sv
// Sprite line scanner top level
`timescale 1ns/100ps

module obj_line_top
    import obj_pkg::*;
(
    input  logic             clk_cpu,
    input  logic             rst,
    input  logic             obank,

    // CPU table writes
    input  logic             cs,
    output logic             ok,
    input  logic [1:0]       dsn,
    input  logic [13:1]      main_addr,
    input  logic [15:0]      main_dout,

    // Line control
    input  logic             line_start,
    input  logic [POS_W-1:0] line,
    output logic             scan_done,

    // Draw-list stream
    output logic             list_valid,
    input  logic             list_ready,
    output logic [15:0]      list_code,
    output logic [POS_W-1:0] list_x,
    output logic [3:0]       list_hsize,
    output logic             list_xflip,
    output logic [4:0]       list_pal,
    output logic [3:0]       list_row
);

    // RAM to scan and checkers
    logic [OBJ_AW-1:0] obj_addr;
    logic [15:0]       obj_x;
    logic [15:0]       obj_y;
    logic [15:0]       obj_code;
    logic [15:0]       obj_attr;
    logic              ent_valid;

    // Checkers to list builder
    logic              v_valid;
    logic              v_hit;
    logic [3:0]        v_tile_row;
    logic [3:0]        v_pix_row;
    logic [15:0]       ent_code;
    logic [3:0]        ent_hsize;
    logic              ent_xflip;
    logic [4:0]        ent_pal;
    logic              h_vis;
    logic [POS_W-1:0]  ent_x;

    // Builder back to scan control
    logic [2:0]        list_space;
    logic              pipe_busy;

    obj_ram u_ram (
        .clk_cpu   (clk_cpu),
        .rst       (rst),
        .obank     (obank),
        .cs        (cs),
        .ok        (ok),
        .dsn       (dsn),
        .main_addr (main_addr),
        .main_dout (main_dout),
        .obj_addr  (obj_addr),
        .obj_x     (obj_x),
        .obj_y     (obj_y),
        .obj_code  (obj_code),
        .obj_attr  (obj_attr)
    );

    obj_scan_ctrl u_scan (
        .clk_cpu    (clk_cpu),
        .rst        (rst),
        .line_start (line_start),
        .obj_attr   (obj_attr),
        .list_space (list_space),
        .pipe_busy  (pipe_busy),
        .obj_addr   (obj_addr),
        .ent_valid  (ent_valid),
        .scan_done  (scan_done)
    );

    obj_vcheck u_vcheck (
        .clk_cpu    (clk_cpu),
        .rst        (rst),
        .line       (line),
        .ent_valid  (ent_valid),
        .obj_y      (obj_y),
        .obj_attr   (obj_attr),
        .obj_code   (obj_code),
        .v_valid    (v_valid),
        .v_hit      (v_hit),
        .v_tile_row (v_tile_row),
        .v_pix_row  (v_pix_row),
        .ent_code   (ent_code),
        .ent_hsize  (ent_hsize),
        .ent_xflip  (ent_xflip),
        .ent_pal    (ent_pal)
    );

    obj_hcheck u_hcheck (
        .clk_cpu   (clk_cpu),
        .rst       (rst),
        .ent_valid (ent_valid),
        .obj_x     (obj_x),
        .obj_attr  (obj_attr),
        .h_vis     (h_vis),
        .ent_x     (ent_x)
    );

    obj_list_build u_list (
        .clk_cpu    (clk_cpu),
        .rst        (rst),
        .v_valid    (v_valid),
        .v_hit      (v_hit),
        .v_tile_row (v_tile_row),
        .v_pix_row  (v_pix_row),
        .ent_code   (ent_code),
        .ent_hsize  (ent_hsize),
        .ent_xflip  (ent_xflip),
        .ent_pal    (ent_pal),
        .h_vis      (h_vis),
        .ent_x      (ent_x),
        .list_valid (list_valid),
        .list_ready (list_ready),
        .list_code  (list_code),
        .list_x     (list_x),
        .list_hsize (list_hsize),
        .list_xflip (list_xflip),
        .list_pal   (list_pal),
        .list_row   (list_row),
        .list_space (list_space),
        .pipe_busy  (pipe_busy)
    );

endmodule

// File: obj_line_sva.sv
// Line scanner interface checks
`timescale 1ns/100ps

module obj_line_sva
    import obj_pkg::*;
(
    input logic             clk_cpu,
    input logic             rst,
    input logic             cs,
    input logic             ok,
    input logic             scan_done,
    input logic             list_valid,
    input logic             list_ready,
    input logic [15:0]      list_code,
    input logic [POS_W-1:0] list_x,
    input logic [3:0]       list_hsize,
    input logic             list_xflip,
    input logic [4:0]       list_pal,
    input logic [3:0]       list_row
);

    // Failed assertions, read back by the testbench
    int err_count = 0;

    // Write acknowledge trails cs by one clock
    a_ok_follows_cs: assert property (@(posedge clk_cpu) disable iff (rst)
        ok == $past(cs))
        else begin
            $error("ok does not follow cs of the previous cycle");
            err_count++;
        end

    // Stalled head entry stays put
    a_list_hold: assert property (@(posedge clk_cpu) disable iff (rst)
        list_valid && !list_ready |=> list_valid &&
        $stable({list_code, list_x, list_hsize, list_xflip, list_pal, list_row}))
        else begin
            $error("list entry dropped or changed before it was accepted");
            err_count++;
        end

    // One cycle only
    a_done_pulse: assert property (@(posedge clk_cpu) disable iff (rst)
        scan_done |=> !scan_done)
        else begin
            $error("scan_done longer than one cycle");
            err_count++;
        end

    // Quiet outputs out of reset
    a_reset_quiet: assert property (@(posedge clk_cpu)
        rst |=> !ok && !list_valid && !scan_done)
        else begin
            $error("output valid right after reset");
            err_count++;
        end

endmodule

bind obj_line_top obj_line_sva u_sva (.*);

// File: tb_obj_line_top.sv
// Sprite line scanner testbench
`timescale 1ns/100ps

module tb_obj_line_top
    import obj_pkg::*;
();

    // One draw-list entry as the stream shows it
    typedef struct packed {
        logic [15:0]      code;
        logic [POS_W-1:0] x;
        logic [3:0]       hsize;
        logic             xflip;
        logic [4:0]       pal;
        logic [3:0]       row;
    } list_ent_t;

    logic             clk_cpu;
    logic             rst;
    logic             obank;
    logic             cs;
    logic             ok;
    logic [1:0]       dsn;
    logic [13:1]      main_addr;
    logic [15:0]      main_dout;
    logic             line_start;
    logic [POS_W-1:0] line;
    logic             scan_done;
    logic             list_valid;
    logic             list_ready;
    logic [15:0]      list_code;
    logic [POS_W-1:0] list_x;
    logic [3:0]       list_hsize;
    logic             list_xflip;
    logic [4:0]       list_pal;
    logic [3:0]       list_row;

    // Shadow of both banks indexed by {bank, entry}
    logic [15:0] shadow [0:3][0:2*OBJ_ENTRIES-1];
    list_ent_t   exp_q [$];
    int          exp_total;
    int          got_count;
    logic        random_ready;
    logic [31:0] lfsr = 32'h10f2;

    obj_line_top UUT (.*);

    initial begin
        clk_cpu = 1'b0;
        forever begin
            #20 clk_cpu = ~clk_cpu;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input logic [15:0] want,
                                 input logic [15:0] got);
        if (got !== want) begin
            report_error($sformatf("Mismatch %s: expected 0x%0h, got 0x%0h", name, want, got));
        end
    endtask

    task automatic check_list_entry(input list_ent_t want);
        compare_field("list_code", want.code, list_code);
        compare_field("list_x", 16'(want.x), 16'(list_x));
        compare_field("list_hsize", 16'(want.hsize), 16'(list_hsize));
        compare_field("list_xflip", 16'(want.xflip), 16'(list_xflip));
        compare_field("list_pal", 16'(want.pal), 16'(list_pal));
        compare_field("list_row", 16'(want.row), 16'(list_row));
    endtask

    task automatic check_ok(input logic want);
        compare_field("ok", 16'(want), 16'(ok));
    endtask

    task automatic check_count(input logic [OBJ_AW:0] got, input logic [OBJ_AW:0] want);
        compare_field("entry_count", 16'(want), 16'(got));
    endtask

    // Expected draw list for one line of one bank
    function automatic void ref_scan(input logic [POS_W-1:0] ln, input logic bank);
        logic [OBJ_AW:0] a;
        logic [15:0]     attr;
        int              off;
        int              span;
        int              x;
        int              trow;
        int              prow;
        list_ent_t       e;
        for (int i = 0; i < OBJ_ENTRIES; i++) begin
            a = {bank, OBJ_AW'(i)};
            attr = shadow[3][a];
            if (attr[15:8] == END_TAG) begin
                break;
            end
            // Line distance below the sprite top modulo 1024
            off = (int'(ln) - int'(shadow[1][a][POS_W-1:0]) + (1 << POS_W)) % (1 << POS_W);
            span = (int'(attr[11:8]) + 1) * TILE_PX;
            x = shadow[0][a][POS_W-1:0];
            if (off < (int'(attr[15:12]) + 1) * TILE_PX &&
                (x < SCREEN_W || x >= (1 << POS_W) - span)) begin
                trow = off / TILE_PX;
                prow = off % TILE_PX;
                // yflip mirrors tile and pixel row
                if (attr[6]) begin
                    trow = int'(attr[15:12]) - trow;
                    prow = prow ^ 15;
                end
                e.code  = shadow[2][a] + 16'(trow * TILE_PX);
                e.x     = POS_W'(x);
                e.hsize = attr[11:8];
                e.xflip = attr[5];
                e.pal   = attr[4:0];
                e.row   = 4'(prow);
                exp_q.push_back(e);
            end
        end
    endfunction

    // One cs cycle with ok checked on the next two cycles
    task automatic write_word(input logic rel, input int idx, input int word,
                              input logic [15:0] data, input logic [1:0] lanes_n);
        logic [OBJ_AW:0] a;
        a = {obank ^ rel, OBJ_AW'(idx)};
        cs        = 1'b1;
        dsn       = lanes_n;
        main_addr = {rel, OBJ_AW'(idx), 2'(word)};
        main_dout = data;
        if (!lanes_n[0]) begin
            shadow[word][a][7:0] = data[7:0];
        end
        if (!lanes_n[1]) begin
            shadow[word][a][15:8] = data[15:8];
        end
        @(negedge clk_cpu);
        check_ok(1'b1);
        cs  = 1'b0;
        dsn = 2'b11;
        @(negedge clk_cpu);
        check_ok(1'b0);
    endtask

    // n random entries aimed near line ln and an end marker at entry n
    task automatic fill_bank(input logic rel, input int n, input logic [POS_W-1:0] ln);
        logic [15:0] attr;
        logic [15:0] xw;
        int          span;
        for (int e = 0; e < n; e++) begin
            attr = 16'(rand_bits(16));
            if (attr[15:8] == END_TAG) begin
                attr[8] = 1'b0;
            end
            span = (int'(attr[11:8]) + 1) * TILE_PX;
            // X near the right screen edge, the wrap edge, or anywhere
            case (rand_bits(2))
                0: xw = 16'(rand_bits(10));
                1: xw = 16'(SCREEN_W - 8 + int'(rand_bits(4)));
                2: xw = 16'((1 << POS_W) - span - 8 + int'(rand_bits(4)));
                default: xw = 16'(rand_bits(9));
            endcase
            write_word(rel, e, 0, xw, 2'b00);
            write_word(rel, e, 1, 16'(ln - POS_W'(rand_bits(8))), 2'b00);
            write_word(rel, e, 2, 16'(rand_bits(16)), 2'b00);
            write_word(rel, e, 3, attr, 2'b00);
        end
        write_word(rel, n, 3, {END_TAG, 8'(rand_bits(8))}, 2'b00);
    endtask

    // Single byte lanes on code and X
    task automatic edit_lanes(input logic rel, input int n);
        for (int e = 0; e < n; e++) begin
            write_word(rel, e, 2, 16'(rand_bits(16)), 2'b10);
            write_word(rel, e, 2, 16'(rand_bits(16)), 2'b01);
            write_word(rel, e, 0, 16'(rand_bits(16)), 2'b01);
        end
    endtask

    task automatic wait_scan_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_cpu);
            cycles++;
            if (cycles > 5000) begin
                report_error("Timeout while waiting for scan_done");
            end
        end while (!scan_done);
    endtask

    task automatic run_scan(input logic [POS_W-1:0] ln, input logic rnd);
        exp_q.delete();
        got_count = 0;
        ref_scan(ln, ~obank);
        exp_total    = exp_q.size();
        line         = ln;
        random_ready <= rnd;
        line_start   = 1'b1;
        @(negedge clk_cpu);
        line_start = 1'b0;
        wait_scan_done();
        random_ready <= 1'b0;
        check_count((OBJ_AW+1)'(got_count), (OBJ_AW+1)'(exp_total));
        @(negedge clk_cpu);
        if (scan_done) begin
            report_error("scan_done stayed high for more than one cycle");
        end
    endtask

    // Sink with back-pressure that compares each accepted entry
    initial begin
        list_ent_t want;
        list_ready = 1'b1;
        forever begin
            @(negedge clk_cpu);
            if (random_ready) begin
                list_ready = rand_bits(1) != 0;
            end else begin
                list_ready = 1'b1;
            end
            // Transfer happens on the coming rising edge
            if (list_valid && list_ready) begin
                if (exp_q.size() == 0) begin
                    report_error("Draw-list entry arrived beyond the expected list");
                end
                want = exp_q.pop_front();
                check_list_entry(want);
                got_count++;
            end
        end
    end

    initial begin
        rst          = 1'b1;
        obank        = 1'b0;
        cs           = 1'b0;
        dsn          = 2'b11;
        main_addr    = '0;
        main_dout    = '0;
        line_start   = 1'b0;
        line         = '0;
        random_ready = 1'b0;
        repeat (5) @(negedge clk_cpu);
        rst = 1'b0;
        @(negedge clk_cpu);
        // Bank 1 on display while obank is low
        fill_bank(1'b1, 24, 10'd200);
        fill_bank(1'b0, 20, 10'd6);
        run_scan(10'd200, 1'b0);
        run_scan(10'd200, 1'b1);
        run_scan(10'd120, 1'b1);
        edit_lanes(1'b1, 8);
        run_scan(10'd200, 1'b1);
        // Swap so bank 0 is displayed and Y wraps past line 1023
        obank = 1'b1;
        run_scan(10'd6, 1'b1);
        run_scan(10'd1020, 1'b1);
        // Writes land in bank 1 while the display stays
        fill_bank(1'b0, 12, 10'd300);
        run_scan(10'd6, 1'b1);
        obank = 1'b0;
        run_scan(10'd300, 1'b1);
        // Marker in entry 0
        fill_bank(1'b1, 0, 10'd0);
        run_scan(10'd0, 1'b1);
        if (UUT.u_sva.err_count != 0) begin
            report_error("Bound interface assertions failed during the run");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: obj_line_top.f
obj_pkg.sv
obj_ram.sv
obj_scan_ctrl.sv
obj_vcheck.sv
obj_hcheck.sv
obj_list_build.sv
obj_line_top.sv
obj_line_sva.sv
tb_obj_line_top.sv

// File: Bender.yml
package:
  name: obj_line_scan

sources:
  - files:
      - obj_pkg.sv
      - obj_ram.sv
      - obj_scan_ctrl.sv
      - obj_vcheck.sv
      - obj_hcheck.sv
      - obj_list_build.sv
      - obj_line_top.sv
  - target: simulation
    files:
      - obj_line_sva.sv
      - tb_obj_line_top.sv
